// ==== tb.f ====
verilog/arbiter_pkg.sv
verilog/apb_if.sv
verilog/static_priority_arbiter.sv
verilog/timeout_static_priority_arbiter.sv
verilog/apb_port_buffer.sv
verilog/apb_request_mux.sv
verilog/apb_register_memory.sv
verilog/apb_shared_memory.sv
verification/tb_apb_shared_memory.sv

// ==== Makefile ====
# Verilator build and run of the APB shared memory testbench

VERILATOR ?= verilator
TOP       ?= tb_apb_shared_memory
RTL_TOP   ?= apb_shared_memory
FILE_LIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_TEXT ?= Finished with errors
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then echo "Simulation reported failure"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILE_LIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/tb_apb_shared_memory.sv ====
// Directed tests for 4 ports, DEPTH 16, TIMEOUT 4; expected data comes from a model of the memory
`default_nettype none

module tb_apb_shared_memory;
  timeunit 1ns;
  timeprecision 100ps;
  import arbiter_pkg::*;

  localparam int num_ports     = 4;
  localparam int depth         = 16;
  localparam int timeout_count = 4;
  localparam int ready_limit   = 60;

  logic                                  clock;
  logic                                  resetn;
  logic [num_ports-1:0]                  psel;
  logic [num_ports-1:0]                  penable;
  logic [num_ports-1:0]                  pwrite;
  logic [num_ports-1:0][addr_width-1:0]  paddr;
  logic [num_ports-1:0][data_width-1:0]  pwdata;
  logic [num_ports-1:0][data_width-1:0]  prdata;
  logic [num_ports-1:0]                  pready;
  logic [num_ports-1:0]                  pslverr;

  // Expected memory contents
  logic [data_width-1:0] model_mem [depth];

  int seed;
  int test_errors;
  int total_errors;
  int tests_run;
  int tests_failed;

  // Completion counts for the starvation test
  logic watch_starvation;
  logic port3_finished;
  int   port0_completions;
  int   port0_before_port3;

  apb_shared_memory #(
    .NUM_PORTS (num_ports),
    .DEPTH     (depth),
    .TIMEOUT   (timeout_count),
    .VARIANT   ("fast")
  ) apb_shared_memory_inst (
    .clock   (clock),
    .resetn  (resetn),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  always @(negedge clock) begin
    if (watch_starvation) begin
      if (pready[0]) port0_completions++;
      if (pready[3] && !port3_finished) begin
        port3_finished     = 1'b1;
        port0_before_port3 = port0_completions;
      end
    end
  end

  task automatic check_equal(input string name, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("Fail %s: %s expected 0x%08h actual 0x%08h", name, what, expected, actual);
      test_errors++;
      total_errors++;
    end
  endtask

  // One APB transfer on one port; latency counts falling edges from access phase to pready
  task automatic apb_access(input int port, input logic write, input logic [7:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic error, output int latency);
    logic seen;
    @(negedge clock);
    psel[port]    = 1'b1;
    penable[port] = 1'b0;
    pwrite[port]  = write;
    paddr[port]   = addr;
    pwdata[port]  = wdata;
    @(negedge clock);
    penable[port] = 1'b1;
    seen    = 1'b0;
    latency = 0;
    while (!seen && latency < ready_limit) begin
      @(negedge clock);
      latency++;
      seen = pready[port];
    end
    if (!seen) begin
      $display("Port %0d saw no pready within %0d cycles of its access phase", port, ready_limit);
      test_errors++;
      total_errors++;
    end
    rdata = prdata[port];
    error = pslverr[port];
    // Hold until the rising edge that ends the transfer
    @(negedge clock);
    psel[port]    = 1'b0;
    penable[port] = 1'b0;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("Test %s passed", name);
    end else begin
      tests_failed++;
      $display("Test %s failed with %0d errors", name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic read_reset_state();
    logic [31:0] rdata;
    logic        error;
    int          latency;
    check_equal("reset_state", "pready", 0, 32'(pready));
    for (int a = 0; a < depth; a++) begin
      apb_access(2, 1'b0, 8'(a), '0, rdata, error, latency);
      check_equal("reset_state", "read data", 0, rdata);
      check_equal("reset_state", "pslverr", 0, 32'(error));
    end
    finish_test("reset_state");
  endtask

  task automatic write_and_read_back();
    logic [31:0] data;
    logic [31:0] rdata;
    logic        error;
    int          latency;
    int          addr;
    for (int k = 0; k < num_ports; k++) begin
      addr = 4 + k;
      data = $random(seed);
      apb_access(k, 1'b1, 8'(addr), data, rdata, error, latency);
      model_mem[addr] = data;
      check_equal("write_read_back", "write pslverr", 0, 32'(error));
      check_equal("write_read_back", "write latency", 4, latency);
      // Read back through the next port
      apb_access((k + 1) % num_ports, 1'b0, 8'(addr), '0, rdata, error, latency);
      check_equal("write_read_back", "read data", model_mem[addr], rdata);
      check_equal("write_read_back", "read latency", 4, latency);
    end
    finish_test("write_read_back");
  endtask

  task automatic access_out_of_range();
    logic [31:0] data;
    logic [31:0] rdata;
    logic        error;
    int          latency;
    data = $random(seed);
    apb_access(1, 1'b1, 8'd0, data, rdata, error, latency);
    model_mem[0] = data;
    check_equal("range_error", "in-range pslverr", 0, 32'(error));
    // Out of range write must not alias onto address 0
    apb_access(1, 1'b1, 8'(depth), ~data, rdata, error, latency);
    check_equal("range_error", "write pslverr", 1, 32'(error));
    apb_access(2, 1'b0, 8'(depth), '0, rdata, error, latency);
    check_equal("range_error", "read data", 0, rdata);
    check_equal("range_error", "read pslverr", 1, 32'(error));
    apb_access(0, 1'b0, 8'd0, '0, rdata, error, latency);
    check_equal("range_error", "address 0 data", model_mem[0], rdata);
    finish_test("range_error");
  endtask

  task automatic contend_two_ports();
    logic [31:0] data1;
    logic [31:0] data3;
    logic [31:0] rdata1;
    logic [31:0] rdata3;
    logic        error1;
    logic        error3;
    int          latency1;
    int          latency3;
    data1 = $random(seed);
    data3 = $random(seed);
    fork
      apb_access(1, 1'b1, 8'd2, data1, rdata1, error1, latency1);
      apb_access(3, 1'b1, 8'd3, data3, rdata3, error3, latency3);
    join
    model_mem[2] = data1;
    model_mem[3] = data3;
    check_equal("static_priority", "port 1 latency", 4, latency1);
    // Port 3 waits for the whole port 1 transfer
    check_equal("static_priority", "port 3 latency", 7, latency3);
    assert (latency3 > latency1) else begin
      $display("Port 3 completed before port 1 although port 1 has priority");
      test_errors++;
      total_errors++;
    end
    finish_test("static_priority");
  endtask

  task automatic starve_low_port();
    logic [31:0] data3;
    logic [31:0] rdata;
    logic        error3;
    int          latency3;
    port0_completions  = 0;
    port0_before_port3 = 0;
    port3_finished     = 1'b0;
    watch_starvation   = 1'b1;
    data3 = $random(seed);
    fork
      begin : port0_burst
        logic [31:0] data0;
        logic [31:0] rdata0;
        logic        error0;
        int          latency0;
        for (int i = 0; i < timeout_count + 2; i++) begin
          data0 = $random(seed);
          apb_access(0, 1'b1, 8'(8 + i), data0, rdata0, error0, latency0);
          model_mem[8 + i] = data0;
          check_equal("starvation_guard", "port 0 pslverr", 0, 32'(error0));
        end
      end
      apb_access(3, 1'b1, 8'd14, data3, rdata, error3, latency3);
    join
    watch_starvation = 1'b0;
    model_mem[14] = data3;
    check_equal("starvation_guard", "port 3 pslverr", 0, 32'(error3));
    check_equal("starvation_guard", "port 3 completion", 1, 32'(port3_finished));
    assert (port0_before_port3 >= 1 && port0_before_port3 <= timeout_count) else begin
      $display("Fail starvation_guard: port 0 transfers before port 3 expected 1 to %0d actual %0d",
               timeout_count, port0_before_port3);
      test_errors++;
      total_errors++;
    end
    for (int a = 8; a <= 14; a++) begin
      apb_access(1, 1'b0, 8'(a), '0, rdata, error3, latency3);
      check_equal("starvation_guard", "read-back data", model_mem[a], rdata);
    end
    finish_test("starvation_guard");
  endtask

  initial begin
    psel             = '0;
    penable          = '0;
    pwrite           = '0;
    paddr            = '0;
    pwdata           = '0;
    resetn           = 1'b0;
    watch_starvation = 1'b0;
    port3_finished   = 1'b0;
    seed             = 32'h632ddd28;
    test_errors      = 0;
    total_errors     = 0;
    tests_run        = 0;
    tests_failed     = 0;
    for (int a = 0; a < depth; a++) begin
      model_mem[a] = '0;
    end
    // Two cycles of reset, released on a falling edge
    repeat (2) @(posedge clock);
    @(negedge clock);
    resetn = 1'b1;
    read_reset_state();
    write_and_read_back();
    access_out_of_range();
    contend_two_ports();
    starve_low_port();
    $display("Tests run %0d, tests failed %0d, check errors %0d",
             tests_run, tests_failed, total_errors);
    if (total_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/apb_shared_memory.sv ====
// NUM_PORTS >= 2 APB masters share one memory; port 0 never times out; 4-cycle best latency
`default_nettype none

module apb_shared_memory #(
  parameter int NUM_PORTS = 4,
  parameter int DEPTH     = 16,
  parameter int TIMEOUT   = 4,
  parameter     VARIANT   = "fast"
) (
  input  wire logic                                              clock,
  input  wire logic                                              resetn,
  input  wire logic [NUM_PORTS-1:0]                              psel,
  input  wire logic [NUM_PORTS-1:0]                              penable,
  input  wire logic [NUM_PORTS-1:0]                              pwrite,
  input  wire logic [NUM_PORTS-1:0][arbiter_pkg::addr_width-1:0] paddr,
  input  wire logic [NUM_PORTS-1:0][arbiter_pkg::data_width-1:0] pwdata,
  output logic      [NUM_PORTS-1:0][arbiter_pkg::data_width-1:0] prdata,
  output logic      [NUM_PORTS-1:0]                              pready,
  output logic      [NUM_PORTS-1:0]                              pslverr
);
  import arbiter_pkg::*;

  logic [NUM_PORTS-1:0]                  pending;
  logic [NUM_PORTS-1:0]                  grant;
  logic                                  enable;
  logic [NUM_PORTS-1:0]                  done;
  logic [data_width-1:0]                 done_rdata;
  logic                                  done_error;
  logic [NUM_PORTS-1:0]                  req_write;
  logic [NUM_PORTS-1:0][addr_width-1:0]  req_addr;
  logic [NUM_PORTS-1:0][data_width-1:0]  req_wdata;

  // Shared link to the memory
  apb_if memory_bus ();

  // One front end per requester
  for (genvar k = 0; k < NUM_PORTS; k++) begin : gen_port
    apb_port_buffer apb_port_buffer_inst (
      .clock      (clock),
      .resetn     (resetn),
      .psel       (psel[k]),
      .penable    (penable[k]),
      .pwrite     (pwrite[k]),
      .paddr      (paddr[k]),
      .pwdata     (pwdata[k]),
      .prdata     (prdata[k]),
      .pready     (pready[k]),
      .pslverr    (pslverr[k]),
      .pending    (pending[k]),
      .req_write  (req_write[k]),
      .req_addr   (req_addr[k]),
      .req_wdata  (req_wdata[k]),
      .done       (done[k]),
      .done_rdata (done_rdata),
      .done_error (done_error)
    );
  end

  timeout_static_priority_arbiter #(
    .NUM_PORTS (NUM_PORTS),
    .TIMEOUT   (TIMEOUT),
    .VARIANT   (VARIANT)
  ) timeout_static_priority_arbiter_inst (
    .clock    (clock),
    .resetn   (resetn),
    .enable   (enable),
    .requests (pending),
    .grant    (grant)
  );

  apb_request_mux #(
    .NUM_PORTS (NUM_PORTS)
  ) apb_request_mux_inst (
    .clock      (clock),
    .resetn     (resetn),
    .pending    (pending),
    .grant      (grant),
    .enable     (enable),
    .port_addr  (req_addr),
    .port_wdata (req_wdata),
    .port_write (req_write),
    .done       (done),
    .done_rdata (done_rdata),
    .done_error (done_error),
    .memory     (memory_bus.requester)
  );

  apb_register_memory #(
    .DEPTH (DEPTH)
  ) apb_register_memory_inst (
    .clock  (clock),
    .resetn (resetn),
    .bus    (memory_bus.completer)
  );

endmodule

`default_nettype wire

// ==== verilog/apb_register_memory.sv ====
// DEPTH from 2 to 2**addr_width words; contents clear on reset; no wait states
`default_nettype none

module apb_register_memory #(
  parameter int DEPTH = 16
) (
  input wire logic  clock,
  input wire logic  resetn,
  apb_if.completer  bus
);
  import arbiter_pkg::*;

  localparam int index_width = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [data_width-1:0]  words [DEPTH];
  logic                   access;
  logic                   in_range;
  logic [index_width-1:0] word_index;

  assign access   = bus.psel & bus.penable;
  assign in_range = (bus.paddr < DEPTH);

  // Only meaningful while in_range holds
  assign word_index = bus.paddr[index_width-1:0];

  // Every access phase completes at once
  assign bus.pready  = access;
  assign bus.pslverr = access & ~in_range;

  // Out of range reads return zero
  assign bus.prdata = in_range ? words[word_index] : '0;

  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      for (int k = 0; k < DEPTH; k++) begin
        words[k] <= '0;
      end
    end else if (access && bus.pwrite && in_range) begin
      words[word_index] <= bus.pwdata;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/apb_request_mux.sv ====
// Grant must be one-hot; NUM_PORTS >= 2; tolerates wait states though the memory has none
`default_nettype none

module apb_request_mux #(
  parameter int NUM_PORTS = 4
) (
  input  wire logic                                               clock,
  input  wire logic                                               resetn,
  input  wire logic [NUM_PORTS-1:0]                               pending,
  input  wire logic [NUM_PORTS-1:0]                               grant,
  output logic                                                    enable,
  input  wire logic [NUM_PORTS-1:0][arbiter_pkg::addr_width-1:0]  port_addr,
  input  wire logic [NUM_PORTS-1:0][arbiter_pkg::data_width-1:0]  port_wdata,
  input  wire logic [NUM_PORTS-1:0]                               port_write,
  output logic      [NUM_PORTS-1:0]                               done,
  output logic      [arbiter_pkg::data_width-1:0]                 done_rdata,
  output logic                                                    done_error,
  apb_if.requester                                                memory
);
  import arbiter_pkg::*;

  localparam int index_width = $clog2(NUM_PORTS);

  mux_state_t             state;
  mux_state_t             next_state;
  logic [index_width-1:0] selected;
  logic [index_width-1:0] winner;
  logic                   start;

  // One-hot grant to port index
  always_comb begin
    winner = '0;
    for (int k = 0; k < NUM_PORTS; k++) begin
      if (grant[k]) begin
        winner = index_width'(k);
      end
    end
  end

  // A round counts only when the grant matches a live request
  assign start  = |(grant & pending);
  assign enable = (state == IDLE);

  always_comb begin
    next_state = state;
    case (state)
      IDLE:    if (start) next_state = SETUP;
      SETUP:   next_state = ACCESS;
      ACCESS:  if (memory.pready) next_state = IDLE;
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      state    <= IDLE;
      selected <= '0;
    end else begin
      state <= next_state;
      if (state == IDLE && start) begin
        selected <= winner;
      end
    end
  end

  // Winning port drives the memory link for the whole transfer
  assign memory.psel    = (state != IDLE);
  assign memory.penable = (state == ACCESS);
  assign memory.pwrite  = port_write[selected];
  assign memory.paddr   = port_addr[selected];
  assign memory.pwdata  = port_wdata[selected];

  // Completion goes back to the selected port only
  always_comb begin
    done = '0;
    if (state == ACCESS && memory.pready) begin
      done[selected] = 1'b1;
    end
  end

  assign done_rdata = memory.prdata;
  assign done_error = memory.pslverr;

endmodule

`default_nettype wire

// ==== verilog/apb_port_buffer.sv ====
// One access outstanding per port; the master must hold its request until pready
`default_nettype none

module apb_port_buffer (
  input  wire logic                              clock,
  input  wire logic                              resetn,
  input  wire logic                              psel,
  input  wire logic                              penable,
  input  wire logic                              pwrite,
  input  wire logic [arbiter_pkg::addr_width-1:0] paddr,
  input  wire logic [arbiter_pkg::data_width-1:0] pwdata,
  output logic      [arbiter_pkg::data_width-1:0] prdata,
  output logic                                   pready,
  output logic                                   pslverr,
  output logic                                   pending,
  output logic                                   req_write,
  output logic      [arbiter_pkg::addr_width-1:0] req_addr,
  output logic      [arbiter_pkg::data_width-1:0] req_wdata,
  input  wire logic                              done,
  input  wire logic [arbiter_pkg::data_width-1:0] done_rdata,
  input  wire logic                              done_error
);
  import arbiter_pkg::*;

  logic  access;
  resp_t response;

  // Access phase of the attached master
  assign access = psel & penable;

  // Request fields reach the mux straight from the master, which holds them stable
  assign req_write = pwrite;
  assign req_addr  = paddr;
  assign req_wdata = pwdata;

  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      pending <= 1'b0;
      pready  <= 1'b0;
    end else begin
      // Done is a single-cycle pulse, so pready lasts one cycle too
      pready <= done;
      if (done) begin
        pending <= 1'b0;
      end else if (access && !pending && !pready) begin
        // Skip the cycle where the finished transfer is still in its access phase
        pending <= 1'b1;
      end
    end
  end

  // Completion data kept for the pready cycle
  always_ff @(posedge clock) begin
    if (done) begin
      response.error <= done_error;
      response.rdata <= done_rdata;
    end
  end

  assign prdata = response.rdata;

  // Error is only meaningful alongside pready
  assign pslverr = pready & response.error;

endmodule

`default_nettype wire

// ==== verilog/timeout_static_priority_arbiter.sv ====
// Needs NUM_PORTS >= 2 and TIMEOUT >= 1; state only moves on cycles with enable high
`default_nettype none

module timeout_static_priority_arbiter #(
  parameter int NUM_PORTS = 4,
  parameter int TIMEOUT   = 4,
  parameter     VARIANT   = "fast"
) (
  input  wire logic                 clock,
  input  wire logic                 resetn,
  input  wire logic                 enable,
  input  wire logic [NUM_PORTS-1:0] requests,
  output logic      [NUM_PORTS-1:0] grant
);

  // Countdown wide enough to hold TIMEOUT-1, at least one bit
  localparam int count_width = (TIMEOUT > 1) ? $clog2(TIMEOUT) : 1;
  localparam logic [count_width-1:0] reload_value = count_width'(TIMEOUT - 1);

  // Channel 0 always wins, so it has no countdown
  logic [count_width-1:0] countdown [NUM_PORTS-1:1];

  // Pending but lost in the last round
  logic [NUM_PORTS-1:1] not_granted;

  logic [NUM_PORTS-1:1] timed_out;
  logic [NUM_PORTS-1:1] decrement;
  logic [NUM_PORTS-1:1] reload;
  logic [NUM_PORTS-1:0] priority_requests;

  for (genvar k = 1; k < NUM_PORTS; k++) begin : gen_timed_out
    assign timed_out[k] = not_granted[k] & (countdown[k] == '0);
  end

  // Count a lost round only while still asking and not yet promoted
  assign decrement = not_granted & requests[NUM_PORTS-1:1] & ~timed_out;

  // A promoted channel starts over once it is served
  assign reload = timed_out & grant[NUM_PORTS-1:1];

  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      not_granted <= '0;
      for (int k = 1; k < NUM_PORTS; k++) begin
        countdown[k] <= reload_value;
      end
    end else if (enable) begin
      // History only advances once per arbitration round
      not_granted <= requests[NUM_PORTS-1:1] & ~grant[NUM_PORTS-1:1];
      for (int k = 1; k < NUM_PORTS; k++) begin
        if (decrement[k]) begin
          countdown[k] <= countdown[k] - 1'b1;
        end else if (reload[k]) begin
          countdown[k] <= reload_value;
        end
      end
    end
  end

  // Timed-out channels hide every other request from the core
  assign priority_requests = (|timed_out) ? {timed_out, 1'b0} : requests;

  static_priority_arbiter #(
    .NUM_PORTS (NUM_PORTS),
    .VARIANT   (VARIANT)
  ) static_priority_arbiter_inst (
    .requests (priority_requests),
    .grant    (grant)
  );

endmodule

`default_nettype wire

// ==== verilog/static_priority_arbiter.sv ====
// Purely combinational; any VARIANT other than "fast" builds the ripple form
`default_nettype none

module static_priority_arbiter #(
  parameter int NUM_PORTS = 4,
  parameter     VARIANT   = "fast"
) (
  input  wire logic [NUM_PORTS-1:0] requests,
  output logic      [NUM_PORTS-1:0] grant
);

  generate
    if (VARIANT == "fast") begin : gen_fast
      // Two's complement keeps only the lowest set bit
      assign grant = requests & (~requests + 1'b1);
    end else begin : gen_small
      // Each stage blocks everything above the first request seen
      logic [NUM_PORTS:0] blocked;

      assign blocked[0] = 1'b0;

      for (genvar k = 0; k < NUM_PORTS; k++) begin : gen_chain
        assign grant[k]     = requests[k] & ~blocked[k];
        assign blocked[k+1] = blocked[k] | requests[k];
      end
    end
  endgenerate

endmodule

`default_nettype wire

// ==== verilog/apb_if.sv ====
// APB link between the request mux and the memory; no pprot or pstrb, whole-word writes
`default_nettype none

interface apb_if;
  import arbiter_pkg::*;

  // Requester side
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [addr_width-1:0] paddr;
  logic [data_width-1:0] pwdata;

  // Completer side
  logic [data_width-1:0] prdata;
  logic                  pready;
  logic                  pslverr;

  modport requester (
    output psel, penable, pwrite, paddr, pwdata,
    input  prdata, pready, pslverr
  );

  modport completer (
    input  psel, penable, pwrite, paddr, pwdata,
    output prdata, pready, pslverr
  );

endinterface

`default_nettype wire

// ==== verilog/arbiter_pkg.sv ====
// Shared widths and types; word addresses only, whole-word data with no byte strobes
`default_nettype none

package arbiter_pkg;

  // Width of pwdata and prdata on every APB link
  localparam int data_width = 32;

  // Word address width; memory depth is limited to 2**addr_width words
  localparam int addr_width = 8;

  // Request mux phases toward the memory
  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS
  } mux_state_t;

  // Completion as held by a port buffer until its master sees pready
  typedef struct packed {
    logic                  error;
    logic [data_width-1:0] rdata;
  } resp_t;

endpackage

`default_nettype wire
